// File: Bender.yml
package:
  name: spad

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/spad_pkg.sv
      - verilog/spad_ram_if.sv
      - verilog/spad_lut_ram.sv
      - verilog/spad_ctrl.sv
      - verilog/spad_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/clk_gen.sv
      - dv/spad_chk.sv
      - dv/spad_tb.sv

// File: compile.f
+incdir+verilog
verilog/spad_pkg.sv
verilog/spad_ram_if.sv
verilog/spad_lut_ram.sv
verilog/spad_ctrl.sv
verilog/spad_top.sv
dv/clk_gen.sv
dv/spad_chk.sv
dv/spad_tb.sv

// File: dv/clk_gen.sv
module clk_gen (
    output logic clk,
    output logic RADDR_RESET
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset spans three rising edges and drops on a falling edge
    initial begin
        RADDR_RESET = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        RADDR_RESET = 1'b0;
    end

endmodule

// File: dv/spad_chk.sv
`include "spad_macros.svh"

module spad_chk (
    input logic                 clk,
    input logic                 RADDR_RESET,
    input logic                 ready,
    input logic                 wr_en,
    input spad_pkg::spad_wren_t wr_be,
    input spad_pkg::spad_addr_t wr_addr,
    input spad_pkg::spad_data_t wr_data,
    input logic                 rd_en,
    input spad_pkg::spad_addr_t rd_addr,
    input logic                 rd_valid,
    input spad_pkg::spad_data_t rd_data
);
    timeunit 1ns;
    timeprecision 1ps;
    import spad_pkg::*;

    localparam int LANEW = `SPAD_DATAW / `SPAD_WRENW;

    spad_data_t shadow [`SPAD_SIZE];
    spad_data_t exp_rdata;
    logic       rd_pend = 1'b0;
    logic       armed = 1'b0;
    int         clr_cycles = 0;
    logic       exp_ready;
    int         err_cnt = 0;
    int         rd_checked = 0;

    // the memory becomes usable once the walk has covered every entry
    assign exp_ready = (clr_cycles == `SPAD_SIZE);

    function automatic spad_data_t merge_bytes(spad_data_t old_word, spad_data_t new_word,
                                               spad_wren_t mask);
        spad_data_t res;
        res = old_word;
        for (int i = 0; i < `SPAD_WRENW; i++) begin
            if (mask[i]) begin
                res[i*LANEW +: LANEW] = new_word[i*LANEW +: LANEW];
            end
        end
        return res;
    endfunction

    always @(posedge clk) begin
        armed <= armed | RADDR_RESET;
        if (RADDR_RESET) begin
            clr_cycles <= 0;
            rd_pend    <= 1'b0;
            for (int i = 0; i < `SPAD_SIZE; i++) begin
                shadow[i] <= '0;
            end
        end else begin
            if (clr_cycles < `SPAD_SIZE) begin
                clr_cycles <= clr_cycles + 1;
            end
            if (wr_en && exp_ready) begin
                shadow[wr_addr] <= merge_bytes(shadow[wr_addr], wr_data, wr_be);
            end
            // with write-first a same-cycle write to the read address is already visible
            rd_pend <= rd_en && exp_ready;
            if (rd_en && exp_ready) begin
                if (wr_en && (wr_addr == rd_addr)) begin
                    exp_rdata <= merge_bytes(shadow[rd_addr], wr_data, wr_be);
                end else begin
                    exp_rdata <= shadow[rd_addr];
                end
            end
            if (rd_pend) begin
                rd_checked <= rd_checked + 1;
            end
        end
    end

    a_ready_reset: assert property (@(posedge clk) armed && RADDR_RESET |-> ready === 1'b0)
        else begin
            err_cnt = err_cnt + 1;
            $error("MISMATCH t=%0t signal=ready expected=0 actual=%b", $time, $sampled(ready));
        end

    a_ready_timing: assert property (@(posedge clk) armed && !RADDR_RESET |-> ready === exp_ready)
        else begin
            err_cnt = err_cnt + 1;
            $error("MISMATCH t=%0t signal=ready expected=%b actual=%b",
                   $time, $sampled(exp_ready), $sampled(ready));
        end

    a_rd_valid: assert property (@(posedge clk) armed |-> rd_valid === rd_pend)
        else begin
            err_cnt = err_cnt + 1;
            $error("MISMATCH t=%0t signal=rd_valid expected=%b actual=%b",
                   $time, $sampled(rd_pend), $sampled(rd_valid));
        end

    a_rd_data: assert property (@(posedge clk) rd_pend |-> rd_data === exp_rdata)
        else begin
            err_cnt = err_cnt + 1;
            $error("MISMATCH t=%0t signal=rd_data expected=%h actual=%h",
                   $time, $sampled(exp_rdata), $sampled(rd_data));
        end

endmodule

// File: dv/spad_tb.sv
`include "spad_macros.svh"

module spad_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import spad_pkg::*;

    localparam int N_PART = 16;
    localparam int N_SAME = 8;
    localparam int N_DIFF = 8;
    // reset, clear walk, three full sweeps, the directed loops and a short tail
    localparam int TEST_CYCLES = 3 + `SPAD_SIZE + 3 * `SPAD_SIZE + 2 * N_PART + N_SAME
                                 + 2 * N_DIFF + 8;
    localparam int TIMEOUT_NS = 2 * TEST_CYCLES * 40;

    logic       clk;
    logic       RADDR_RESET;
    logic       ready;
    logic       wr_en;
    spad_wren_t wr_be;
    spad_addr_t wr_addr;
    spad_data_t wr_data;
    logic       rd_en;
    spad_addr_t rd_addr;
    logic       rd_valid;
    spad_data_t rd_data;
    int         n_wr = 0;
    int         n_rd = 0;

    clk_gen u_clk_gen (
        .clk         (clk),
        .RADDR_RESET (RADDR_RESET)
    );

    spad_top uut (
        .clk         (clk),
        .RADDR_RESET (RADDR_RESET),
        .ready       (ready),
        .wr_en       (wr_en),
        .wr_be       (wr_be),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data)
    );

    bind spad_top spad_chk u_chk (
        .clk         (clk),
        .RADDR_RESET (RADDR_RESET),
        .ready       (ready),
        .wr_en       (wr_en),
        .wr_be       (wr_be),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data)
    );

    task automatic drive_cycle(input logic we, input spad_wren_t be, input spad_addr_t waddr,
                               input spad_data_t wdata, input logic re, input spad_addr_t raddr);
        @(negedge clk);
        wr_en   = we;
        wr_be   = be;
        wr_addr = waddr;
        wr_data = wdata;
        rd_en   = re;
        rd_addr = raddr;
        if (we) begin
            n_wr++;
        end
        if (re) begin
            n_rd++;
        end
    endtask

    task automatic drive_idle();
        drive_cycle(1'b0, '0, '0, '0, 1'b0, '0);
    endtask

    // requests during reset and the clear walk must all be dropped
    task automatic poke_until_ready();
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (ready === 1'b1) begin
                done  = 1'b1;
                wr_en = 1'b0;
                rd_en = 1'b0;
            end else begin
                wr_en   = 1'b1;
                wr_be   = spad_wren_t'($urandom);
                wr_addr = spad_addr_t'($urandom);
                wr_data = $urandom;
                rd_en   = 1'b1;
                rd_addr = spad_addr_t'($urandom);
            end
        end
    endtask

    initial begin
        spad_addr_t a;
        spad_wren_t be;
        void'($urandom(32'h4bf4_6fb3));
        wr_en   = 1'b0;
        wr_be   = '0;
        wr_addr = '0;
        wr_data = '0;
        rd_en   = 1'b0;
        rd_addr = '0;

        poke_until_ready();

        for (int i = 0; i < `SPAD_SIZE; i++) begin
            drive_cycle(1'b0, '0, '0, '0, 1'b1, spad_addr_t'(i));
        end
        drive_idle();

        for (int i = 0; i < `SPAD_SIZE; i++) begin
            drive_cycle(1'b1, '1, spad_addr_t'(i), $urandom, 1'b0, '0);
        end
        for (int i = 0; i < `SPAD_SIZE; i++) begin
            drive_cycle(1'b0, '0, '0, '0, 1'b1, spad_addr_t'(i));
        end
        drive_idle();

        repeat (N_PART) begin
            a  = spad_addr_t'($urandom);
            be = spad_wren_t'($urandom);
            drive_cycle(1'b1, be, a, $urandom, 1'b0, '0);
            drive_cycle(1'b0, '0, '0, '0, 1'b1, a);
        end

        repeat (N_SAME) begin
            a  = spad_addr_t'($urandom);
            be = spad_wren_t'($urandom);
            drive_cycle(1'b1, be, a, $urandom, 1'b1, a);
        end

        // the read of the neighbour must not see the write
        repeat (N_DIFF) begin
            a  = spad_addr_t'($urandom);
            be = spad_wren_t'($urandom);
            drive_cycle(1'b1, be, a, $urandom, 1'b1, a + spad_addr_t'(1));
            drive_cycle(1'b0, '0, '0, '0, 1'b1, a);
        end

        repeat (3) drive_idle();

        $display("closing: writes issued %0d, reads issued %0d, reads checked %0d, errors %0d",
                 n_wr, n_rd, uut.u_chk.rd_checked, uut.u_chk.err_cnt);
        if (uut.u_chk.err_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: test sequence did not finish within %0d ns", TIMEOUT_NS);
        $display("tests failed");
        $finish;
    end

endmodule

// File: verilog/spad_ctrl.sv
`include "spad_macros.svh"

module spad_ctrl (
    input  logic                 clk,
    input  logic                 RADDR_RESET,
    output logic                 ready,

    input  logic                 wr_en,
    input  spad_pkg::spad_wren_t wr_be,
    input  spad_pkg::spad_addr_t wr_addr,
    input  spad_pkg::spad_data_t wr_data,

    input  logic                 rd_en,
    input  spad_pkg::spad_addr_t rd_addr,
    output logic                 rd_valid,
    output spad_pkg::spad_data_t rd_data,

    spad_ram_if.ctrl             ram
);
    import spad_pkg::*;

    clr_state_e state;
    clr_state_e state_next;
    spad_addr_t clr_cnt;
    logic       clr_last;
    logic       wr_acc;
    logic       rd_acc;

    assign clr_last = (clr_cnt == spad_addr_t'(`SPAD_SIZE - 1));

    always_comb begin
        state_next = state;
        case (state)
            CLR_BUSY: begin
                if (clr_last) begin
                    state_next = CLR_DONE;
                end
            end
            default: begin
                state_next = CLR_DONE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (RADDR_RESET) begin
            state <= CLR_BUSY;
        end else begin
            state <= state_next;
        end
    end

    // walks one entry per cycle while the clear is running
    always_ff @(posedge clk) begin
        if (RADDR_RESET) begin
            clr_cnt <= '0;
        end else if (state == CLR_BUSY) begin
            clr_cnt <= clr_cnt + spad_addr_t'(1);
        end
    end

    assign ready  = (state == CLR_DONE);
    assign wr_acc = wr_en && ready;
    assign rd_acc = rd_en && ready;

    // the clear walk owns the write port until every entry holds zero
    always_comb begin
        if (state == CLR_BUSY) begin
            ram.write = 1'b1;
            ram.wren  = '1;
            ram.waddr = clr_cnt;
            ram.wdata = '0;
        end else begin
            ram.write = wr_acc;
            ram.wren  = wr_be;
            ram.waddr = wr_addr;
            ram.wdata = wr_data;
        end
    end

    assign ram.read  = rd_acc;
    assign ram.raddr = rd_addr;
    assign rd_data   = ram.rdata;

    // rd_valid lines up with the RAM read latency
    if (`SPAD_RADDR_REG != 0) begin : g_rd_valid_reg
        logic rd_valid_r;

        always_ff @(posedge clk) begin
            if (RADDR_RESET) begin
                rd_valid_r <= 1'b0;
            end else begin
                rd_valid_r <= rd_acc;
            end
        end

        assign rd_valid = rd_valid_r;
    end else begin : g_rd_valid_comb
        assign rd_valid = rd_acc;
    end

endmodule

// File: verilog/spad_lut_ram.sv
module spad_lut_ram #(
    parameter int DATAW       = 32,
    parameter int SIZE        = 16,
    parameter int WRENW       = 4,
    parameter bit RADDR_REG   = 1'b1,
    parameter bit WRITE_FIRST = 1'b1
) (
    input logic   clk,
    spad_ram_if.ram ram
);

    localparam int ADDRW = $clog2(SIZE);
    localparam int WSELW = DATAW / WRENW;

    logic [DATAW-1:0] mem [SIZE];

    // each lane is written only when its enable bit is set
    always_ff @(posedge clk) begin
        if (ram.write) begin
            for (int i = 0; i < WRENW; i++) begin
                if (ram.wren[i]) begin
                    mem[ram.waddr][i*WSELW +: WSELW] <= ram.wdata[i*WSELW +: WSELW];
                end
            end
        end
    end

    if (RADDR_REG) begin : g_sync_read
        if (WRITE_FIRST) begin : g_write_first
            logic [ADDRW-1:0] raddr_r;

            // the array is read after the edge, so a write on the same edge
            // is already visible through the registered address
            always_ff @(posedge clk) begin
                if (ram.read) begin
                    raddr_r <= ram.raddr;
                end
            end

            assign ram.rdata = mem[raddr_r];
        end else begin : g_read_first
            logic [DATAW-1:0] rdata_r;

            // old contents are sampled on the same edge the write lands
            always_ff @(posedge clk) begin
                if (ram.read) begin
                    rdata_r <= mem[ram.raddr];
                end
            end

            assign ram.rdata = rdata_r;
        end
    end else begin : g_async_read
        if (WRITE_FIRST) begin : g_write_first
            logic [DATAW-1:0] rdata_fwd;

            // forward the enabled lanes of a pending write to the same entry
            always_comb begin
                rdata_fwd = mem[ram.raddr];
                if (ram.write && (ram.waddr == ram.raddr)) begin
                    for (int i = 0; i < WRENW; i++) begin
                        if (ram.wren[i]) begin
                            rdata_fwd[i*WSELW +: WSELW] = ram.wdata[i*WSELW +: WSELW];
                        end
                    end
                end
            end

            assign ram.rdata = rdata_fwd;
        end else begin : g_read_first
            assign ram.rdata = mem[ram.raddr];
        end
    end

endmodule

// File: verilog/spad_macros.svh
`ifndef SPAD_MACROS_SVH
`define SPAD_MACROS_SVH

// the scratchpad holds 16 words of 32 bits with one enable per byte
`define SPAD_DATAW 32
`define SPAD_SIZE 16
`define SPAD_WRENW 4
`define SPAD_ADDRW 4

// read timing and same-address collision behavior of the RAM
`define SPAD_RADDR_REG 1
`define SPAD_WRITE_FIRST 1

`endif

// File: verilog/spad_pkg.sv
`include "spad_macros.svh"

package spad_pkg;

    // one stored word
    typedef logic [`SPAD_DATAW-1:0] spad_data_t;

    // entry index into the scratchpad
    typedef logic [`SPAD_ADDRW-1:0] spad_addr_t;

    // one bit per byte lane
    typedef logic [`SPAD_WRENW-1:0] spad_wren_t;

    // the memory is unusable until the clear walk has covered every entry
    typedef enum logic {
        CLR_BUSY = 1'b0,
        CLR_DONE = 1'b1
    } clr_state_e;

endpackage

// File: verilog/spad_ram_if.sv
interface spad_ram_if;
    import spad_pkg::*;

    // write port
    logic       write;
    spad_wren_t wren;
    spad_addr_t waddr;
    spad_data_t wdata;

    // read port
    logic       read;
    spad_addr_t raddr;
    spad_data_t rdata;

    modport ctrl (
        output write, wren, waddr, wdata,
        output read, raddr,
        input  rdata
    );

    modport ram (
        input  write, wren, waddr, wdata,
        input  read, raddr,
        output rdata
    );

endinterface

// File: verilog/spad_top.sv
`include "spad_macros.svh"

module spad_top (
    input  logic                 clk,
    input  logic                 RADDR_RESET,
    output logic                 ready,

    input  logic                 wr_en,
    input  spad_pkg::spad_wren_t wr_be,
    input  spad_pkg::spad_addr_t wr_addr,
    input  spad_pkg::spad_data_t wr_data,

    input  logic                 rd_en,
    input  spad_pkg::spad_addr_t rd_addr,
    output logic                 rd_valid,
    output spad_pkg::spad_data_t rd_data
);

    spad_ram_if ram_if ();

    spad_ctrl u_ctrl (
        .clk         (clk),
        .RADDR_RESET (RADDR_RESET),
        .ready       (ready),
        .wr_en       (wr_en),
        .wr_be       (wr_be),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .ram         (ram_if.ctrl)
    );

    // registered read address with write-first collisions
    spad_lut_ram #(
        .DATAW       (`SPAD_DATAW),
        .SIZE        (`SPAD_SIZE),
        .WRENW       (`SPAD_WRENW),
        .RADDR_REG   (`SPAD_RADDR_REG),
        .WRITE_FIRST (`SPAD_WRITE_FIRST)
    ) u_ram (
        .clk (clk),
        .ram (ram_if.ram)
    );

endmodule
